//--- logic/udp_proto_pkg.sv
package udp_proto_pkg;

  // IPv4 address and UDP field words
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] len16_t;

  // Fixed IPv4 header size, no options
  localparam int unsigned ip_hdr_len = 20;

  // UDP header as seen by the framer (bytes) and the parser (fields).
  // Byte 0 of the byte view is the first byte on the wire.
  typedef union packed {
    struct packed {
      udp_port_t source_port;
      udp_port_t dest_port;
      len16_t    length;
      len16_t    checksum;
    } f;
    logic [0:7][7:0] b;
  } udp_hdr_t;

endpackage

//--- logic/udp_stream_pkg.sv
package udp_stream_pkg;

  // One beat of the byte stream
  localparam int unsigned stream_width = 8;
  typedef logic [stream_width-1:0] byte_t;

  // UDP header is carried as the first payload bytes
  localparam int unsigned udp_hdr_bytes = 8;
  localparam int unsigned hdr_idx_width = $clog2(udp_hdr_bytes);
  typedef logic [hdr_idx_width-1:0] hdr_idx_t;

  // Payload byte counter, wide enough for any UDP length
  localparam int unsigned len_cnt_width = 16;
  typedef logic [len_cnt_width-1:0] len_cnt_t;

endpackage

//--- logic/frame_ctrl_if.sv
`timescale 1ns/1ns

interface frame_ctrl_if;
  import udp_stream_pkg::*;
  import udp_proto_pkg::*;

  logic     hdr_load;
  hdr_idx_t hdr_idx;
  logic     hdr_phase;
  logic     pay_phase;
  logic     hdr_out_valid;
  len16_t   udp_len;

  modport ctrl (
    output hdr_load, hdr_idx, hdr_phase, pay_phase, hdr_out_valid,
    input  udp_len
  );

  modport dp (
    input  hdr_load, hdr_idx, hdr_phase, pay_phase, hdr_out_valid,
    output udp_len
  );

endinterface

//--- logic/udp_flow_ctrl.sv
`timescale 1ns/1ns

module udp_flow_ctrl (
  input  logic        clk,
  input  logic        reset,
  frame_ctrl_if.ctrl  tx,
  frame_ctrl_if.ctrl  rx,
  input  logic        s_udp_hdr_valid,
  output logic        s_udp_hdr_ready,
  input  logic        s_udp_payload_tvalid,
  output logic        s_udp_payload_tready,
  input  logic        s_udp_payload_tlast,
  output logic        m_ip_hdr_valid,
  input  logic        m_ip_hdr_ready,
  output logic        m_ip_payload_tvalid,
  input  logic        m_ip_payload_tready,
  output logic        m_ip_payload_tlast,
  input  logic        s_ip_hdr_valid,
  output logic        s_ip_hdr_ready,
  input  logic        s_ip_payload_tvalid,
  output logic        s_ip_payload_tready,
  input  logic        s_ip_payload_tlast,
  output logic        m_udp_hdr_valid,
  input  logic        m_udp_hdr_ready,
  output logic        m_udp_payload_tvalid,
  input  logic        m_udp_payload_tready,
  output logic        m_udp_payload_tlast,
  output logic        tx_busy,
  output logic        rx_busy,
  output logic        rx_error_header_early_termination,
  output logic        rx_error_payload_early_termination
);
  import udp_stream_pkg::*;

  // Transmit states
  localparam logic [1:0] tx_idle      = 2'd0;
  localparam logic [1:0] tx_hdr_out   = 2'd1;
  localparam logic [1:0] tx_hdr_bytes = 2'd2;
  localparam logic [1:0] tx_payload   = 2'd3;

  // Receive states
  localparam logic [1:0] rx_idle     = 2'd0;
  localparam logic [1:0] rx_assemble = 2'd1;
  localparam logic [1:0] rx_hdr_out  = 2'd2;
  localparam logic [1:0] rx_payload  = 2'd3;

  localparam hdr_idx_t last_idx = hdr_idx_t'(udp_hdr_bytes - 1);

  logic [1:0] tx_state;
  logic [1:0] tx_next;
  logic [1:0] rx_state;
  logic [1:0] rx_next;
  hdr_idx_t   tx_idx;
  hdr_idx_t   rx_idx;
  len_cnt_t   rx_cnt;
  logic       tx_hdr_phase;
  logic       tx_pay_phase;
  logic       rx_beat;
  logic       rx_short;
  logic       hdr_err;
  logic       pay_err;

  assign tx_hdr_phase = (tx_state == tx_hdr_bytes);
  assign tx_pay_phase = (tx_state == tx_payload);

  // Transmit handshakes
  assign m_ip_hdr_valid       = (tx_state == tx_hdr_out);
  assign m_ip_payload_tvalid  = tx_hdr_phase || (tx_pay_phase && s_udp_payload_tvalid);
  assign m_ip_payload_tlast   = tx_pay_phase && s_udp_payload_tlast;
  assign s_udp_payload_tready = tx_pay_phase && m_ip_payload_tready;
  assign tx_busy              = (tx_state != tx_idle);

  assign tx.hdr_idx       = tx_idx;
  assign tx.hdr_phase     = tx_hdr_phase;
  assign tx.pay_phase     = tx_pay_phase;
  assign tx.hdr_out_valid = m_ip_hdr_valid;

  always_comb begin
    tx_next     = tx_state;
    tx.hdr_load = 1'b0;
    case (tx_state)
      tx_idle: begin
        if (s_udp_hdr_valid && s_udp_hdr_ready) begin
          tx.hdr_load = 1'b1;
          tx_next     = tx_hdr_out;
        end
      end
      tx_hdr_out: begin
        if (m_ip_hdr_ready) begin
          tx_next = tx_hdr_bytes;
        end
      end
      tx_hdr_bytes: begin
        if (m_ip_payload_tready && tx_idx == last_idx) begin
          tx_next = tx_payload;
        end
      end
      default: begin
        if (s_udp_payload_tvalid && m_ip_payload_tready && s_udp_payload_tlast) begin
          tx_next = tx_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_state        <= tx_idle;
      tx_idx          <= '0;
      s_udp_hdr_ready <= 1'b0;
    end else begin
      tx_state        <= tx_next;
      s_udp_hdr_ready <= (tx_next == tx_idle);
      if (m_ip_hdr_valid) begin
        tx_idx <= '0;
      end else if (tx_hdr_phase && m_ip_payload_tready) begin
        tx_idx <= tx_idx + hdr_idx_t'(1);
      end
    end
  end

  // Receive handshakes
  assign rx_beat = s_ip_payload_tvalid && s_ip_payload_tready;

  assign m_udp_hdr_valid      = (rx_state == rx_hdr_out);
  assign s_ip_payload_tready  = (rx_state == rx_assemble) ||
                                (rx_state == rx_payload && m_udp_payload_tready);
  assign m_udp_payload_tvalid = (rx_state == rx_payload) && s_ip_payload_tvalid;
  assign m_udp_payload_tlast  = (rx_state == rx_payload) && s_ip_payload_tlast;
  assign rx_busy              = (rx_state != rx_idle);

  assign rx.hdr_idx       = rx_idx;
  assign rx.hdr_phase     = (rx_state == rx_assemble) && s_ip_payload_tvalid;
  assign rx.pay_phase     = (rx_state == rx_payload);
  assign rx.hdr_out_valid = m_udp_hdr_valid;

  // Payload ends short when this beat count plus the header is below the UDP length
  assign rx_short = (rx_cnt + len_cnt_t'(udp_hdr_bytes + 1)) < rx.udp_len;

  always_comb begin
    rx_next     = rx_state;
    rx.hdr_load = 1'b0;
    hdr_err     = 1'b0;
    pay_err     = 1'b0;
    case (rx_state)
      rx_idle: begin
        if (s_ip_hdr_valid && s_ip_hdr_ready) begin
          rx.hdr_load = 1'b1;
          rx_next     = rx_assemble;
        end
      end
      rx_assemble: begin
        if (s_ip_payload_tvalid) begin
          if (s_ip_payload_tlast) begin
            // Frame too short for a UDP header, drop it
            hdr_err = 1'b1;
            rx_next = rx_idle;
          end else if (rx_idx == last_idx) begin
            rx_next = rx_hdr_out;
          end
        end
      end
      rx_hdr_out: begin
        if (m_udp_hdr_ready) begin
          rx_next = rx_payload;
        end
      end
      default: begin
        if (rx_beat && s_ip_payload_tlast) begin
          pay_err = rx_short;
          rx_next = rx_idle;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_state                           <= rx_idle;
      rx_idx                             <= '0;
      rx_cnt                             <= '0;
      s_ip_hdr_ready                     <= 1'b0;
      rx_error_header_early_termination  <= 1'b0;
      rx_error_payload_early_termination <= 1'b0;
    end else begin
      rx_state                           <= rx_next;
      s_ip_hdr_ready                     <= (rx_next == rx_idle);
      rx_error_header_early_termination  <= hdr_err;
      rx_error_payload_early_termination <= pay_err;
      if (rx.hdr_load) begin
        rx_idx <= '0;
      end else if (rx.hdr_phase) begin
        rx_idx <= rx_idx + hdr_idx_t'(1);
      end
      if (m_udp_hdr_valid) begin
        rx_cnt <= '0;
      end else if (rx.pay_phase && rx_beat) begin
        rx_cnt <= rx_cnt + len_cnt_t'(1);
      end
    end
  end

endmodule

//--- logic/udp_tx_framer.sv
`timescale 1ns/1ns

module udp_tx_framer (
  input  logic                     clk,
  input  logic                     reset,
  frame_ctrl_if.dp                 ctrl,
  input  udp_proto_pkg::udp_port_t roce_udp_port,
  input  udp_proto_pkg::ip_addr_t  s_udp_source_ip,
  input  udp_proto_pkg::ip_addr_t  s_udp_dest_ip,
  input  udp_proto_pkg::udp_port_t s_udp_source_port,
  input  udp_proto_pkg::udp_port_t s_udp_dest_port,
  input  udp_proto_pkg::len16_t    s_udp_length,
  input  udp_proto_pkg::len16_t    s_udp_checksum,
  input  udp_stream_pkg::byte_t    s_udp_payload_tdata,
  output udp_proto_pkg::ip_addr_t  m_ip_source_ip,
  output udp_proto_pkg::ip_addr_t  m_ip_dest_ip,
  output udp_proto_pkg::len16_t    m_ip_length,
  output logic                     m_is_roce_packet,
  output udp_stream_pkg::byte_t    m_ip_payload_tdata
);
  import udp_proto_pkg::*;

  udp_hdr_t tx_hdr;
  ip_addr_t src_ip;
  ip_addr_t dst_ip;
  logic     roce_q;

  // Header fields held for the whole frame
  always_ff @(posedge clk) begin
    if (ctrl.hdr_load) begin
      tx_hdr.f.source_port <= s_udp_source_port;
      tx_hdr.f.dest_port   <= s_udp_dest_port;
      tx_hdr.f.length      <= s_udp_length;
      tx_hdr.f.checksum    <= s_udp_checksum;
      src_ip               <= s_udp_source_ip;
      dst_ip               <= s_udp_dest_ip;
    end
  end

  // RoCE match on the destination port
  always_ff @(posedge clk) begin
    if (reset) begin
      roce_q <= 1'b0;
    end else if (ctrl.hdr_load) begin
      roce_q <= (s_udp_dest_port == roce_udp_port);
    end
  end

  assign m_ip_source_ip   = src_ip;
  assign m_ip_dest_ip     = dst_ip;
  assign m_ip_length      = tx_hdr.f.length + len16_t'(ip_hdr_len);
  assign m_is_roce_packet = roce_q && ctrl.hdr_out_valid;
  assign ctrl.udp_len     = tx_hdr.f.length;

  // Header bytes first, then payload straight through
  always_comb begin
    if (ctrl.hdr_phase) begin
      m_ip_payload_tdata = tx_hdr.b[ctrl.hdr_idx];
    end else if (ctrl.pay_phase) begin
      m_ip_payload_tdata = s_udp_payload_tdata;
    end else begin
      m_ip_payload_tdata = '0;
    end
  end

endmodule

//--- logic/udp_rx_parser.sv
`timescale 1ns/1ns

module udp_rx_parser (
  input  logic                     clk,
  input  logic                     reset,
  frame_ctrl_if.dp                 ctrl,
  input  udp_proto_pkg::ip_addr_t  s_ip_source_ip,
  input  udp_proto_pkg::ip_addr_t  s_ip_dest_ip,
  input  udp_stream_pkg::byte_t    s_ip_payload_tdata,
  output udp_proto_pkg::ip_addr_t  m_udp_source_ip,
  output udp_proto_pkg::ip_addr_t  m_udp_dest_ip,
  output udp_proto_pkg::udp_port_t m_udp_source_port,
  output udp_proto_pkg::udp_port_t m_udp_dest_port,
  output udp_proto_pkg::len16_t    m_udp_length,
  output udp_proto_pkg::len16_t    m_udp_checksum,
  output udp_stream_pkg::byte_t    m_udp_payload_tdata
);
  import udp_proto_pkg::*;

  udp_hdr_t rx_hdr;
  ip_addr_t src_ip;
  ip_addr_t dst_ip;

  always_ff @(posedge clk) begin
    if (ctrl.hdr_load) begin
      src_ip <= s_ip_source_ip;
      dst_ip <= s_ip_dest_ip;
    end
  end

  // Fill the header one wire byte at a time
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_hdr <= '0;
    end else if (ctrl.hdr_phase) begin
      rx_hdr.b[ctrl.hdr_idx] <= s_ip_payload_tdata;
    end
  end

  assign m_udp_source_ip   = src_ip;
  assign m_udp_dest_ip     = dst_ip;
  assign m_udp_source_port = rx_hdr.f.source_port;
  assign m_udp_dest_port   = rx_hdr.f.dest_port;
  assign m_udp_length      = rx_hdr.f.length;
  assign m_udp_checksum    = rx_hdr.f.checksum;

  // Length feeds the short-frame check in the controller
  assign ctrl.udp_len = rx_hdr.f.length;

  assign m_udp_payload_tdata = ctrl.pay_phase ? s_ip_payload_tdata : '0;

endmodule

//--- logic/udp_top.sv
`timescale 1ns/1ns

module udp_top (
  input  logic                     clk,
  input  logic                     reset,
  input  udp_proto_pkg::udp_port_t roce_udp_port,
  // UDP frame in
  input  logic                     s_udp_hdr_valid,
  output logic                     s_udp_hdr_ready,
  input  udp_proto_pkg::ip_addr_t  s_udp_source_ip,
  input  udp_proto_pkg::ip_addr_t  s_udp_dest_ip,
  input  udp_proto_pkg::udp_port_t s_udp_source_port,
  input  udp_proto_pkg::udp_port_t s_udp_dest_port,
  input  udp_proto_pkg::len16_t    s_udp_length,
  input  udp_proto_pkg::len16_t    s_udp_checksum,
  input  udp_stream_pkg::byte_t    s_udp_payload_tdata,
  input  logic                     s_udp_payload_tvalid,
  output logic                     s_udp_payload_tready,
  input  logic                     s_udp_payload_tlast,
  // IP frame out
  output logic                     m_ip_hdr_valid,
  input  logic                     m_ip_hdr_ready,
  output udp_proto_pkg::ip_addr_t  m_ip_source_ip,
  output udp_proto_pkg::ip_addr_t  m_ip_dest_ip,
  output udp_proto_pkg::len16_t    m_ip_length,
  output logic                     m_is_roce_packet,
  output udp_stream_pkg::byte_t    m_ip_payload_tdata,
  output logic                     m_ip_payload_tvalid,
  input  logic                     m_ip_payload_tready,
  output logic                     m_ip_payload_tlast,
  // IP frame in
  input  logic                     s_ip_hdr_valid,
  output logic                     s_ip_hdr_ready,
  input  udp_proto_pkg::ip_addr_t  s_ip_source_ip,
  input  udp_proto_pkg::ip_addr_t  s_ip_dest_ip,
  input  udp_stream_pkg::byte_t    s_ip_payload_tdata,
  input  logic                     s_ip_payload_tvalid,
  output logic                     s_ip_payload_tready,
  input  logic                     s_ip_payload_tlast,
  // UDP frame out
  output logic                     m_udp_hdr_valid,
  input  logic                     m_udp_hdr_ready,
  output udp_proto_pkg::ip_addr_t  m_udp_source_ip,
  output udp_proto_pkg::ip_addr_t  m_udp_dest_ip,
  output udp_proto_pkg::udp_port_t m_udp_source_port,
  output udp_proto_pkg::udp_port_t m_udp_dest_port,
  output udp_proto_pkg::len16_t    m_udp_length,
  output udp_proto_pkg::len16_t    m_udp_checksum,
  output udp_stream_pkg::byte_t    m_udp_payload_tdata,
  output logic                     m_udp_payload_tvalid,
  input  logic                     m_udp_payload_tready,
  output logic                     m_udp_payload_tlast,
  // Status
  output logic                     tx_busy,
  output logic                     rx_busy,
  output logic                     rx_error_header_early_termination,
  output logic                     rx_error_payload_early_termination
);

  frame_ctrl_if tx_ctrl ();
  frame_ctrl_if rx_ctrl ();

  // Outer port names match the submodule ports
  udp_flow_ctrl flow_ctrl_i (
    .tx (tx_ctrl),
    .rx (rx_ctrl),
    .*
  );

  udp_tx_framer tx_framer_i (
    .ctrl (tx_ctrl),
    .*
  );

  udp_rx_parser rx_parser_i (
    .ctrl (rx_ctrl),
    .*
  );

endmodule

//--- tests/udp_tb.sv
`timescale 1ns/1ns

module udp_tb;
  import udp_proto_pkg::*;
  import udp_stream_pkg::*;

  localparam udp_port_t roce_port = 16'd4791;
  localparam int timeout_cycles = 200;
  localparam int ch_udp_hdr = 0;
  localparam int ch_udp_pay = 1;
  localparam int ch_ip_hdr  = 2;
  localparam int ch_ip_pay  = 3;

  logic clk = 1'b0;
  logic reset;
  integer seed = 10747;
  logic [31:0] rnd;
  logic s_udp_hdr_valid, s_udp_hdr_ready, s_udp_payload_tvalid, s_udp_payload_tready;
  logic s_udp_payload_tlast, m_ip_hdr_valid, m_is_roce_packet, m_ip_payload_tvalid;
  logic m_ip_payload_tlast, s_ip_hdr_valid, s_ip_hdr_ready, s_ip_payload_tvalid;
  logic s_ip_payload_tready, s_ip_payload_tlast, m_udp_hdr_valid, m_udp_payload_tvalid;
  logic m_udp_payload_tlast, tx_busy, rx_busy;
  logic rx_error_header_early_termination, rx_error_payload_early_termination;
  logic m_ip_hdr_ready = 1'b0;
  logic m_ip_payload_tready = 1'b0;
  logic m_udp_hdr_ready = 1'b0;
  logic m_udp_payload_tready = 1'b0;
  ip_addr_t  s_udp_source_ip, s_udp_dest_ip, m_ip_source_ip, m_ip_dest_ip;
  ip_addr_t  s_ip_source_ip, s_ip_dest_ip, m_udp_source_ip, m_udp_dest_ip;
  udp_port_t s_udp_source_port, s_udp_dest_port, m_udp_source_port, m_udp_dest_port;
  udp_port_t roce_udp_port;
  len16_t    s_udp_length, s_udp_checksum, m_ip_length, m_udp_length, m_udp_checksum;
  byte_t     s_udp_payload_tdata, m_ip_payload_tdata, s_ip_payload_tdata, m_udp_payload_tdata;

  // Reference model: {tlast, data} per expected output beat
  logic [8:0] tx_q[$];
  logic [8:0] rx_q[$];
  logic [8:0] tx_head, rx_head;
  logic tx_have = 1'b0;
  logic rx_have = 1'b0;
  len16_t    exp_ip_len, exp_len, exp_csum;
  ip_addr_t  exp_tx_src, exp_tx_dst, exp_rx_src, exp_rx_dst;
  udp_port_t exp_sport, exp_dport;
  logic exp_roce, rx_hdr_expected, exp_hdr_err, exp_pay_err;

  // Header handshakes seen on the two outputs
  int tx_hdr_cnt = 0;
  int rx_hdr_cnt = 0;

  wire tx_beat = m_ip_payload_tvalid && m_ip_payload_tready;
  wire rx_beat = m_udp_payload_tvalid && m_udp_payload_tready;

  udp_top dut_i (.*);

  always #10 clk = ~clk;

  task automatic stop_fail(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
    stop_fail($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  // Random back-pressure on every sink
  always @(posedge clk) begin
    #1;
    rnd = $random(seed);
    m_ip_hdr_ready       = !reset && rnd[0];
    m_ip_payload_tready  = !reset && rnd[5];
    m_udp_hdr_ready      = !reset && rnd[9];
    m_udp_payload_tready = !reset && rnd[13];
  end

  // Inputs only move after the rising edge, so the negedge sees the next transfer
  always @(negedge clk) begin
    if (tx_beat) begin
      tx_have = (tx_q.size() != 0);
      if (tx_have) begin
        tx_head = tx_q.pop_front();
      end
    end
    if (rx_beat) begin
      rx_have = (rx_q.size() != 0);
      if (rx_have) begin
        rx_head = rx_q.pop_front();
      end
    end
    if (m_ip_hdr_valid && m_ip_hdr_ready) begin
      tx_hdr_cnt++;
    end
    if (m_udp_hdr_valid && m_udp_hdr_ready) begin
      rx_hdr_cnt++;
    end
  end

  a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> !(s_udp_hdr_ready ||
      s_udp_payload_tready || m_ip_hdr_valid || m_ip_payload_tvalid || s_ip_hdr_ready ||
      s_ip_payload_tready || m_udp_hdr_valid || m_udp_payload_tvalid || tx_busy || rx_busy ||
      rx_error_header_early_termination || rx_error_payload_early_termination))
    else stop_fail("Outputs were not idle in the first cycle after reset");
  a_ip_len: assert property (@(posedge clk) m_ip_hdr_valid |-> m_ip_length == exp_ip_len)
    else value_fail("m_ip_length", 32'($sampled(m_ip_length)), 32'(exp_ip_len));
  a_ip_src: assert property (@(posedge clk) m_ip_hdr_valid |-> m_ip_source_ip == exp_tx_src)
    else value_fail("m_ip_source_ip", $sampled(m_ip_source_ip), exp_tx_src);
  a_ip_dst: assert property (@(posedge clk) m_ip_hdr_valid |-> m_ip_dest_ip == exp_tx_dst)
    else value_fail("m_ip_dest_ip", $sampled(m_ip_dest_ip), exp_tx_dst);
  a_roce: assert property (@(posedge clk) m_ip_hdr_valid |-> m_is_roce_packet == exp_roce)
    else value_fail("m_is_roce_packet", 32'($sampled(m_is_roce_packet)), 32'(exp_roce));
  a_tx_extra: assert property (@(posedge clk) tx_beat |-> tx_have)
    else stop_fail("IP payload produced a byte that was never expected");
  a_tx_data: assert property (@(posedge clk) tx_beat |-> m_ip_payload_tdata == tx_head[7:0])
    else value_fail("m_ip_payload_tdata", 32'($sampled(m_ip_payload_tdata)), 32'(tx_head[7:0]));
  a_tx_last: assert property (@(posedge clk) tx_beat |-> m_ip_payload_tlast == tx_head[8])
    else value_fail("m_ip_payload_tlast", 32'($sampled(m_ip_payload_tlast)), 32'(tx_head[8]));
  a_rx_hdr: assert property (@(posedge clk) m_udp_hdr_valid |-> rx_hdr_expected)
    else stop_fail("UDP header was presented for a frame that should have been dropped");
  a_rx_src: assert property (@(posedge clk) m_udp_hdr_valid |-> m_udp_source_ip == exp_rx_src)
    else value_fail("m_udp_source_ip", $sampled(m_udp_source_ip), exp_rx_src);
  a_rx_dst: assert property (@(posedge clk) m_udp_hdr_valid |-> m_udp_dest_ip == exp_rx_dst)
    else value_fail("m_udp_dest_ip", $sampled(m_udp_dest_ip), exp_rx_dst);
  a_sport: assert property (@(posedge clk) m_udp_hdr_valid |-> m_udp_source_port == exp_sport)
    else value_fail("m_udp_source_port", 32'($sampled(m_udp_source_port)), 32'(exp_sport));
  a_dport: assert property (@(posedge clk) m_udp_hdr_valid |-> m_udp_dest_port == exp_dport)
    else value_fail("m_udp_dest_port", 32'($sampled(m_udp_dest_port)), 32'(exp_dport));
  a_len: assert property (@(posedge clk) m_udp_hdr_valid |-> m_udp_length == exp_len)
    else value_fail("m_udp_length", 32'($sampled(m_udp_length)), 32'(exp_len));
  a_csum: assert property (@(posedge clk) m_udp_hdr_valid |-> m_udp_checksum == exp_csum)
    else value_fail("m_udp_checksum", 32'($sampled(m_udp_checksum)), 32'(exp_csum));
  a_rx_extra: assert property (@(posedge clk) rx_beat |-> rx_have)
    else stop_fail("UDP payload produced a byte that was never expected");
  a_rx_data: assert property (@(posedge clk) rx_beat |-> m_udp_payload_tdata == rx_head[7:0])
    else value_fail("m_udp_payload_tdata", 32'($sampled(m_udp_payload_tdata)), 32'(rx_head[7:0]));
  a_rx_last: assert property (@(posedge clk) rx_beat |-> m_udp_payload_tlast == rx_head[8])
    else value_fail("m_udp_payload_tlast", 32'($sampled(m_udp_payload_tlast)), 32'(rx_head[8]));
  a_hdr_err: assert property (@(posedge clk) rx_error_header_early_termination |-> exp_hdr_err)
    else stop_fail("Header early-termination error pulsed on a frame with a full header");
  a_pay_err: assert property (@(posedge clk) rx_error_payload_early_termination |-> exp_pay_err)
    else stop_fail("Payload early-termination error pulsed on a frame of full length");

  function automatic logic ready_of(input int ch);
    case (ch)
      ch_udp_hdr: return s_udp_hdr_ready;
      ch_udp_pay: return s_udp_payload_tready;
      ch_ip_hdr:  return s_ip_hdr_ready;
      default:    return s_ip_payload_tready;
    endcase
  endfunction

  // Valid stays up until the DUT takes the beat
  task automatic transfer(input int ch, input string what);
    int   cnt = 0;
    logic taken = 1'b0;
    while (!taken) begin
      if (cnt == timeout_cycles) begin
        stop_fail($sformatf("Timed out waiting for the DUT to accept the %s", what));
      end
      @(negedge clk);
      taken = ready_of(ch);
      @(posedge clk);
      #1;
      cnt++;
    end
  endtask

  task automatic send_udp(input udp_port_t sport, input udp_port_t dport, input int n);
    logic [63:0] hdr;
    byte_t       data;
    len16_t      len;
    int          hdr_seen;
    len = len16_t'(n + 8);
    hdr_seen = tx_hdr_cnt;
    exp_tx_src = {16'h0a01, sport};
    exp_tx_dst = {16'hac10, dport};
    exp_ip_len = len + 16'd20;
    exp_roce   = (dport == roce_udp_port);
    hdr = {sport, dport, len, ~sport};
    for (int i = 0; i < 8; i++) begin
      tx_q.push_back({1'b0, hdr[63 - 8*i -: 8]});
    end
    s_udp_source_ip   = exp_tx_src;
    s_udp_dest_ip     = exp_tx_dst;
    s_udp_source_port = sport;
    s_udp_dest_port   = dport;
    s_udp_length      = len;
    s_udp_checksum    = ~sport;
    s_udp_hdr_valid   = 1'b1;
    transfer(ch_udp_hdr, "UDP header");
    s_udp_hdr_valid = 1'b0;
    for (int i = 0; i < n; i++) begin
      data = byte_t'(i * 37 + n);
      tx_q.push_back({i == n - 1, data});
      s_udp_payload_tdata  = data;
      s_udp_payload_tlast  = (i == n - 1);
      s_udp_payload_tvalid = 1'b1;
      transfer(ch_udp_pay, "UDP payload beat");
    end
    s_udp_payload_tvalid = 1'b0;
    s_udp_payload_tlast  = 1'b0;
    // The IP header handshake comes before any payload byte
    assert (tx_hdr_cnt == hdr_seen + 1)
      else stop_fail("IP header was not presented exactly once for a UDP frame");
  endtask

  // hdr_n header bytes reach the wire, then pay_n payload bytes
  task automatic send_ip(input udp_port_t sport, input udp_port_t dport, input len16_t len,
                         input int hdr_n, input int pay_n);
    logic [63:0] hdr;
    byte_t       data;
    int          total;
    int          cnt;
    int          hdr_seen;
    logic        seen;
    hdr_seen   = rx_hdr_cnt;
    exp_rx_src = {16'h0a00, sport};
    exp_rx_dst = {16'hc0a8, dport};
    exp_sport  = sport;
    exp_dport  = dport;
    exp_len    = len;
    exp_csum   = sport ^ dport;
    rx_hdr_expected = (hdr_n == 8);
    exp_hdr_err     = (hdr_n < 8);
    exp_pay_err     = (hdr_n == 8) && (pay_n + 8 < int'(len));
    hdr   = {sport, dport, len, exp_csum};
    total = hdr_n + pay_n;
    s_ip_source_ip = exp_rx_src;
    s_ip_dest_ip   = exp_rx_dst;
    s_ip_hdr_valid = 1'b1;
    transfer(ch_ip_hdr, "IP header");
    s_ip_hdr_valid = 1'b0;
    for (int i = 0; i < total; i++) begin
      data = (i < 8) ? hdr[63 - 8*i -: 8] : byte_t'(i * 29 + 3);
      if (i >= 8) begin
        rx_q.push_back({i == total - 1, data});
      end
      s_ip_payload_tdata  = data;
      s_ip_payload_tlast  = (i == total - 1);
      s_ip_payload_tvalid = 1'b1;
      transfer(ch_ip_pay, "IP payload beat");
    end
    s_ip_payload_tvalid = 1'b0;
    s_ip_payload_tlast  = 1'b0;
    assert (rx_hdr_cnt == hdr_seen + int'(rx_hdr_expected))
      else stop_fail("UDP header presentation count does not match the frame");
    cnt  = 0;
    seen = !(exp_hdr_err || exp_pay_err);
    while (!seen) begin
      if (cnt == timeout_cycles) begin
        stop_fail("Early-termination error pulse never appeared for a short frame");
      end
      @(negedge clk);
      seen = exp_hdr_err ? rx_error_header_early_termination : rx_error_payload_early_termination;
      cnt++;
    end
    // Gap so a late error pulse still meets this frame's expectations
    repeat (3) @(posedge clk);
    #1;
  endtask

  initial begin
    int cnt;
    reset = 1'b1;
    roce_udp_port = roce_port;
    {s_udp_hdr_valid, s_udp_payload_tvalid, s_udp_payload_tlast} = '0;
    {s_ip_hdr_valid, s_ip_payload_tvalid, s_ip_payload_tlast} = '0;
    {s_udp_source_ip, s_udp_dest_ip, s_ip_source_ip, s_ip_dest_ip} = '0;
    {s_udp_source_port, s_udp_dest_port, s_udp_length, s_udp_checksum} = '0;
    s_udp_payload_tdata = '0;
    s_ip_payload_tdata  = '0;
    {rx_hdr_expected, exp_hdr_err, exp_pay_err} = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    send_udp(16'h1234, roce_port, 5);
    send_udp(16'hbeef, 16'd53, 12);
    send_udp(16'h0400, 16'd4790, 1);
    send_ip(16'd5000, 16'd6000, 16'd20, 8, 12);
    send_ip(16'd7001, roce_port, 16'd30, 8, 12);
    send_ip(16'd8080, 16'd80, 16'd16, 3, 0);
    send_ip(16'd1111, 16'd2222, 16'd9, 8, 1);
    cnt = 0;
    while (tx_q.size() != 0 || rx_q.size() != 0) begin
      if (cnt == timeout_cycles) begin
        stop_fail("Expected stream bytes never came out of the DUT");
      end
      @(posedge clk);
      cnt++;
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- list.f
logic/udp_proto_pkg.sv
logic/udp_stream_pkg.sv
logic/frame_ctrl_if.sv
logic/udp_flow_ctrl.sv
logic/udp_tx_framer.sv
logic/udp_rx_parser.sv
logic/udp_top.sv
tests/udp_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = udp_tb
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
